/* Makefile */
SIM      = verilator
SIMFLAGS = --binary --assert -j 0
TOP      = csi_rx_tb
FILELIST = compile.f
OBJDIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out=$$(./$(OBJDIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf $(OBJDIR)

/* byte_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

module byte_assembler (
	input  wire                        mipi_clk_2,
	input  wire                        reset,
	input  wire                        hs_active_i,
	input  wire csi_link_pkg::nibble_t nibble_i,
	input  wire                        locked_i,
	input  wire csi_link_pkg::phase_e  phase_i,
	output csi_link_pkg::byte_t        byte_o,
	output logic                       byte_stb_o
);
	import csi_link_pkg::*;

	byte_t aligned_sr;
	byte_t shifted_sr;
	logic [1:0] carry_bits;
	logic toggle;

	// both alignments run all the time
	always_ff @(posedge mipi_clk_2) begin
		aligned_sr <= {nibble_i, aligned_sr[7:4]};
		shifted_sr <= {nibble_i[1:0], carry_bits, shifted_sr[7:4]};
		carry_bits <= nibble_i[3:2];
		if (locked_i && toggle) begin
			byte_o <= (phase_i == phase_even) ? aligned_sr : shifted_sr;
		end
	end

	// one byte every second cycle after lock
	always_ff @(posedge mipi_clk_2) begin
		if (reset || !hs_active_i) begin
			toggle <= 1'b0;
			byte_stb_o <= 1'b0;
		end else begin
			byte_stb_o <= locked_i & toggle;
			if (locked_i) begin
				toggle <= ~toggle;
			end
		end
	end

endmodule

`default_nettype wire

/* compile.f */
csi_link_pkg.sv
csi_packet_pkg.sv
sync_hunter.sv
byte_assembler.sv
word_packer.sv
header_decoder.sv
line_writer.sv
csi_rx_top.sv
tb_clock_gen.sv
csi_rx_checker.sv
csi_rx_tb.sv

/* csi_link_pkg.sv */
`default_nettype none

package csi_link_pkg;

	//////////////////////////////
	// lane widths
	localparam int nibble_w = 4;
	localparam int byte_w = 8;

	typedef logic [nibble_w-1:0] nibble_t;
	typedef logic [byte_w-1:0] byte_t;

	//////////////////////////////
	// sync byte, whole and two bits late
	localparam byte_t sync_even = 8'hB8;
	localparam logic [5:0] sync_odd_low = 6'h2E;

	typedef enum logic {
		phase_even,
		phase_odd
	} phase_e;

endpackage

`default_nettype wire

/* csi_packet_pkg.sv */
`default_nettype none

package csi_packet_pkg;

	typedef logic [31:0] word_t;
	typedef logic [15:0] word_count_t;
	typedef logic [15:0] crc_t;
	typedef logic [31:0] addr_t;
	typedef logic [15:0] coord_t;

	typedef enum logic [5:0] {
		dt_frame_start = 6'h00,
		dt_frame_end   = 6'h01,
		dt_raw8        = 6'h2A
	} data_type_e;

	localparam int line_bytes = 640;
	localparam int line_words = line_bytes / 4;

	localparam crc_t crc_init = 16'hFFFF;
	localparam crc_t crc_poly = 16'h8408;

	//////////////////////////////
	// hamming parity column of each header bit
	localparam logic [5:0] ecc_col [24] = '{
		6'h07, 6'h0B, 6'h0D, 6'h0E, 6'h13, 6'h15, 6'h16, 6'h19,
		6'h1A, 6'h1C, 6'h23, 6'h25, 6'h26, 6'h29, 6'h2A, 6'h2C,
		6'h31, 6'h32, 6'h34, 6'h38, 6'h1F, 6'h2F, 6'h37, 6'h3B
	};

	function automatic logic [7:0] ecc_calc(input logic [23:0] hdr);
		logic [5:0] p;
		p = '0;
		for (int i = 0; i < 24; i++) begin
			if (hdr[i]) begin
				p = p ^ ecc_col[i];
			end
		end
		return {2'b00, p};
	endfunction

	// returns high when the syndrome points at one header bit
	function automatic logic ecc_syndrome_bit(input logic [7:0] syndrome,
			output logic [4:0] bit_idx);
		logic single;
		single = 1'b0;
		bit_idx = '0;
		for (int i = 0; i < 24; i++) begin
			if (syndrome == {2'b00, ecc_col[i]}) begin
				single = 1'b1;
				bit_idx = 5'(i);
			end
		end
		return single;
	endfunction

	//////////////////////////////
	// crc-16, low byte first, lsb first
	function automatic crc_t crc_next_word(input crc_t crc, input word_t data);
		crc_t c;
		logic fb;
		c = crc;
		for (int i = 0; i < 32; i++) begin
			fb = c[0] ^ data[i];
			c = c >> 1;
			if (fb) begin
				c = c ^ crc_poly;
			end
		end
		return c;
	endfunction

endpackage

`default_nettype wire

/* csi_rx_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module csi_rx_checker (
	input wire                         mipi_clk_2,
	input wire                         reset,
	input wire                         wr_en_i,
	input wire csi_packet_pkg::addr_t  wr_addr_i,
	input wire csi_packet_pkg::coord_t pix_x_i,
	input wire                         crc_ok_i,
	input wire                         crc_err_i
);
	import csi_packet_pkg::*;

	// address of the previous write
	addr_t last_addr;

	always_ff @(posedge mipi_clk_2) begin
		if (wr_en_i) begin
			last_addr <= wr_addr_i;
		end
	end

	crc_flags_exclusive: assert property (@(posedge mipi_clk_2) disable iff (reset)
		!(crc_ok_i && crc_err_i))
		else $error("crc_ok_o and crc_err_o are high in the same cycle");

	no_write_in_reset: assert property (@(posedge mipi_clk_2) reset |=> !wr_en_i)
		else $error("wr_en_o is high during reset");

	// first word of a line has pix_x zero
	addr_steps_by_one: assert property (@(posedge mipi_clk_2) disable iff (reset)
		(wr_en_i && pix_x_i != '0) |-> (wr_addr_i == last_addr + 32'd1))
		else $error("write address inside a line did not advance by one");

endmodule

bind line_writer csi_rx_checker u_checker (
	.mipi_clk_2(mipi_clk_2),
	.reset(reset),
	.wr_en_i(wr_en_o),
	.wr_addr_i(wr_addr_o),
	.pix_x_i(pix_x_o),
	.crc_ok_i(crc_ok_o),
	.crc_err_i(crc_err_o)
);

`default_nettype wire

/* csi_rx_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module csi_rx_tb;
	import csi_link_pkg::*;
	import csi_packet_pkg::*;

	typedef enum logic [2:0] {
		pk_frame_start,
		pk_line,
		pk_unknown,
		pk_flip1,
		pk_flip2,
		pk_bad_crc
	} pkt_kind_e;

	typedef struct packed {
		pkt_kind_e kind;
		phase_e phase;
		logic [3:0] lead;
	} row_t;

	localparam int n_rows = 9;
	localparam int wait_limit = 400;

	// kind, phase, idle nibbles ahead of the sync byte
	row_t rows [n_rows] = '{
		'{pk_frame_start, phase_even, 4'd3},
		'{pk_line, phase_even, 4'd5},
		'{pk_line, phase_odd, 4'd2},
		'{pk_flip1, phase_even, 4'd7},
		'{pk_flip2, phase_odd, 4'd4},
		'{pk_unknown, phase_even, 4'd1},
		'{pk_bad_crc, phase_odd, 4'd6},
		'{pk_frame_start, phase_odd, 4'd3},
		'{pk_line, phase_even, 4'd2}
	};

	logic mipi_clk_2;
	logic reset;
	logic hs_active;
	nibble_t lane0_nibble;
	nibble_t lane1_nibble;
	logic wr_en;
	addr_t wr_addr;
	word_t wr_data;
	coord_t pix_x;
	coord_t pix_y;
	logic crc_ok;
	logic crc_err;
	logic hdr_err;

	logic bits0 [$];
	logic bits1 [$];
	word_t payload [line_words];
	logic [31:0] rng = 32'hcd08;

	word_t got_data [$];
	addr_t got_addr [$];
	coord_t got_x [$];
	coord_t got_y [$];
	int ok_seen = 0;
	int bad_seen = 0;
	int herr_seen = 0;
	int base_wr;
	int base_ok;
	int base_bad;
	int base_herr;

	addr_t exp_addr = '0;
	coord_t exp_y = '0;
	int mismatches = 0;
	int timeouts = 0;

	tb_clock_gen u_clock (
		.mipi_clk_2(mipi_clk_2),
		.reset(reset)
	);

	csi_rx_top UUT (
		.mipi_clk_2(mipi_clk_2),
		.reset(reset),
		.hs_active_i(hs_active),
		.lane0_nibble_i(lane0_nibble),
		.lane1_nibble_i(lane1_nibble),
		.wr_en_o(wr_en),
		.wr_addr_o(wr_addr),
		.wr_data_o(wr_data),
		.pix_x_o(pix_x),
		.pix_y_o(pix_y),
		.crc_ok_o(crc_ok),
		.crc_err_o(crc_err),
		.hdr_err_o(hdr_err)
	);

	//////////////////////////////
	// reference model
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// one parity bit per row of the csi-2 equations
	function automatic logic [5:0] ecc_model(input logic [23:0] h);
		logic [5:0] p;
		p[0] = ^(h & 24'hF12CB7);
		p[1] = ^(h & 24'hF2555B);
		p[2] = ^(h & 24'h749A6D);
		p[3] = ^(h & 24'hB8E38E);
		p[4] = ^(h & 24'hDF03F0);
		p[5] = ^(h & 24'hEFFC00);
		return p;
	endfunction

	function automatic word_t make_header(input logic [5:0] dt, input word_count_t wc);
		logic [23:0] h;
		h = {wc, 2'b00, dt};
		return {2'b00, ecc_model(h), h};
	endfunction

	function automatic crc_t crc_byte(input crc_t crc, input byte_t b);
		crc_t c;
		c = crc;
		for (int i = 0; i < 8; i++) begin
			if (c[0] ^ b[i]) begin
				c = (c >> 1) ^ 16'h8408;
			end else begin
				c = c >> 1;
			end
		end
		return c;
	endfunction

	function automatic logic results_pending(input int n_wr, input int n_ok,
			input int n_bad, input int n_herr);
		return (got_data.size() - base_wr < n_wr) || (ok_seen - base_ok < n_ok)
			|| (bad_seen - base_bad < n_bad) || (herr_seen - base_herr < n_herr);
	endfunction

	//////////////////////////////
	// compares
	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic verify_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_coord(input string name, input coord_t got, input coord_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic expect_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic match_count(input string name, input int got, input int exp);
		if (got != exp) begin
			mismatches++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	//////////////////////////////
	// lane streams
	task automatic push_idle_bits(input int n);
		for (int i = 0; i < n; i++) begin
			bits0.push_back(1'b0);
			bits1.push_back(1'b0);
		end
	endtask

	task automatic push_byte(input int lane, input byte_t b);
		for (int i = 0; i < 8; i++) begin
			if (lane == 0) begin
				bits0.push_back(b[i]);
			end else begin
				bits1.push_back(b[i]);
			end
		end
	endtask

	// byte n on both lanes, then byte n+1
	task automatic push_word(input word_t w);
		push_byte(0, w[7:0]);
		push_byte(1, w[15:8]);
		push_byte(0, w[23:16]);
		push_byte(1, w[31:24]);
	endtask

	task automatic drive_stream();
		for (int i = 0; i < bits0.size(); i += 4) begin
			@(posedge mipi_clk_2);
			hs_active <= 1'b1;
			lane0_nibble <= {bits0[i+3], bits0[i+2], bits0[i+1], bits0[i]};
			lane1_nibble <= {bits1[i+3], bits1[i+2], bits1[i+1], bits1[i]};
		end
		@(posedge mipi_clk_2);
		hs_active <= 1'b0;
		lane0_nibble <= '0;
		lane1_nibble <= '0;
	endtask

	task automatic run_row(input int r);
		row_t row;
		int n_wr;
		int n_ok;
		logic [5:0] dt;
		word_t hdr;
		crc_t crc;
		int cycles;
		row = rows[r];
		n_wr = (row.kind == pk_line || row.kind == pk_flip1 || row.kind == pk_bad_crc) ?
			line_words : 0;
		n_ok = (row.kind == pk_line || row.kind == pk_flip1) ? 1 : 0;
		if (row.kind == pk_frame_start) begin
			dt = 6'h00;
		end else if (row.kind == pk_unknown) begin
			dt = 6'h12;
		end else begin
			dt = 6'h2A;
		end
		hdr = make_header(dt, (row.kind == pk_frame_start) ? 16'd1 : 16'(line_bytes));
		if (row.kind == pk_flip1) begin
			hdr = hdr ^ 32'h0000_0200;
		end else if (row.kind == pk_flip2) begin
			hdr = hdr ^ 32'h0002_0008;
		end
		// a line straight after a line repeats its pixels
		if (!(row.kind == pk_line && r > 0 && rows[r-1].kind == pk_line)) begin
			for (int i = 0; i < line_words; i++) begin
				rng = xorshift32(rng);
				payload[i] = rng;
			end
		end
		crc = 16'hFFFF;
		for (int i = 0; i < line_words; i++) begin
			for (int b = 0; b < 4; b++) begin
				crc = crc_byte(crc, payload[i][8*b +: 8]);
			end
		end
		if (row.kind == pk_bad_crc) begin
			crc = crc ^ 16'h5A5A;
		end

		bits0.delete();
		bits1.delete();
		push_idle_bits(4 * int'(row.lead));
		if (row.phase == phase_odd) begin
			push_idle_bits(2);
		end
		push_byte(0, 8'hB8);
		push_byte(1, 8'hB8);
		push_word(hdr);
		if (row.kind != pk_frame_start) begin
			for (int i = 0; i < line_words; i++) begin
				push_word(payload[i]);
			end
			push_word({16'h0000, crc});
		end
		// flush words so the checksum leaves the pipeline before hs falls
		push_word('0);
		push_word('0);
		while (bits0.size() % 4 != 0) begin
			push_idle_bits(1);
		end

		base_wr = got_data.size();
		base_ok = ok_seen;
		base_bad = bad_seen;
		base_herr = herr_seen;
		drive_stream();

		cycles = 0;
		while (results_pending(n_wr, n_ok, (row.kind == pk_bad_crc) ? 1 : 0,
				(row.kind == pk_flip2) ? 1 : 0) && cycles < wait_limit) begin
			@(posedge mipi_clk_2);
			cycles++;
		end
		if (results_pending(n_wr, n_ok, (row.kind == pk_bad_crc) ? 1 : 0,
				(row.kind == pk_flip2) ? 1 : 0)) begin
			timeouts++;
			$display("timeout: packet %0d did not produce its writes and flags", r);
		end
		// idle gap with hs low
		repeat (8) @(posedge mipi_clk_2);

		match_count("write count", got_data.size() - base_wr, n_wr);
		match_count("crc_ok_o pulses", ok_seen - base_ok, n_ok);
		match_count("crc_err_o pulses", bad_seen - base_bad, (row.kind == pk_bad_crc) ? 1 : 0);
		match_count("hdr_err_o pulses", herr_seen - base_herr, (row.kind == pk_flip2) ? 1 : 0);
		for (int i = 0; i < n_wr && base_wr + i < got_data.size(); i++) begin
			check_word("wr_data_o", got_data[base_wr+i], payload[i]);
			verify_addr("wr_addr_o", got_addr[base_wr+i], exp_addr + addr_t'(i));
			compare_coord("pix_x_o", got_x[base_wr+i], coord_t'(i));
			compare_coord("pix_y_o", got_y[base_wr+i], exp_y);
		end

		if (row.kind == pk_frame_start) begin
			exp_addr = '0;
			exp_y = '0;
		end
		if (n_wr != 0) begin
			exp_addr = exp_addr + addr_t'(line_words);
			exp_y = exp_y + 16'd1;
		end
	endtask

	// outputs settle by the falling edge
	always @(negedge mipi_clk_2) begin
		if (reset === 1'b0) begin
			if (wr_en) begin
				got_data.push_back(wr_data);
				got_addr.push_back(wr_addr);
				got_x.push_back(pix_x);
				got_y.push_back(pix_y);
			end
			if (crc_ok) begin
				ok_seen++;
			end
			if (crc_err) begin
				bad_seen++;
			end
			if (hdr_err) begin
				herr_seen++;
			end
		end
	end

	initial begin
		int cycles;
		hs_active = 1'b0;
		lane0_nibble = '0;
		lane1_nibble = '0;
		cycles = 0;
		while (reset !== 1'b0 && cycles < 50) begin
			@(posedge mipi_clk_2);
			cycles++;
		end
		if (reset !== 1'b0) begin
			timeouts++;
			$display("timeout: reset was never released");
		end
		@(negedge mipi_clk_2);
		expect_flag("wr_en_o", wr_en, 1'b0);
		expect_flag("crc_ok_o", crc_ok, 1'b0);
		expect_flag("crc_err_o", crc_err, 1'b0);
		expect_flag("hdr_err_o", hdr_err, 1'b0);

		for (int r = 0; r < n_rows; r++) begin
			run_row(r);
		end

		$display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* csi_rx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module csi_rx_top (
	input  wire                        mipi_clk_2,
	input  wire                        reset,
	input  wire                        hs_active_i,
	input  wire csi_link_pkg::nibble_t lane0_nibble_i,
	input  wire csi_link_pkg::nibble_t lane1_nibble_i,
	output logic                       wr_en_o,
	output csi_packet_pkg::addr_t      wr_addr_o,
	output csi_packet_pkg::word_t      wr_data_o,
	output csi_packet_pkg::coord_t     pix_x_o,
	output csi_packet_pkg::coord_t     pix_y_o,
	output logic                       crc_ok_o,
	output logic                       crc_err_o,
	output logic                       hdr_err_o
);
	import csi_link_pkg::*;
	import csi_packet_pkg::*;

	logic locked;
	phase_e phase;
	byte_t lane0_byte;
	byte_t lane1_byte;
	logic lane0_stb;
	logic lane1_stb;
	word_t word;
	logic word_stb;
	logic hdr_stb;
	data_type_e dtype;
	word_count_t wcount;
	word_t pay_word;
	logic pay_stb;

	//////////////////////////////
	// lane layer, lane 0 finds sync for both
	sync_hunter u_sync (
		.mipi_clk_2(mipi_clk_2), .reset(reset), .hs_active_i(hs_active_i),
		.nibble_i(lane0_nibble_i), .locked_o(locked), .phase_o(phase)
	);

	byte_assembler u_lane0 (
		.mipi_clk_2(mipi_clk_2), .reset(reset), .hs_active_i(hs_active_i),
		.nibble_i(lane0_nibble_i), .locked_i(locked), .phase_i(phase),
		.byte_o(lane0_byte), .byte_stb_o(lane0_stb)
	);

	byte_assembler u_lane1 (
		.mipi_clk_2(mipi_clk_2), .reset(reset), .hs_active_i(hs_active_i),
		.nibble_i(lane1_nibble_i), .locked_i(locked), .phase_i(phase),
		.byte_o(lane1_byte), .byte_stb_o(lane1_stb)
	);

	//////////////////////////////
	// packet layer
	word_packer u_packer (
		.mipi_clk_2(mipi_clk_2), .reset(reset), .hs_active_i(hs_active_i),
		.lane0_byte_i(lane0_byte), .lane1_byte_i(lane1_byte),
		.byte_stb_i(lane0_stb & lane1_stb), .word_o(word), .word_stb_o(word_stb)
	);

	header_decoder u_header (
		.mipi_clk_2(mipi_clk_2), .reset(reset), .hs_active_i(hs_active_i),
		.word_i(word), .word_stb_i(word_stb), .hdr_stb_o(hdr_stb), .dtype_o(dtype),
		.wcount_o(wcount), .pay_word_o(pay_word), .pay_stb_o(pay_stb),
		.hdr_err_o(hdr_err_o)
	);

	line_writer u_writer (
		.mipi_clk_2(mipi_clk_2), .reset(reset), .hdr_stb_i(hdr_stb), .dtype_i(dtype),
		.wcount_i(wcount), .pay_word_i(pay_word), .pay_stb_i(pay_stb),
		.wr_en_o(wr_en_o), .wr_addr_o(wr_addr_o), .wr_data_o(wr_data_o),
		.pix_x_o(pix_x_o), .pix_y_o(pix_y_o), .crc_ok_o(crc_ok_o), .crc_err_o(crc_err_o)
	);

endmodule

`default_nettype wire

/* header_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module header_decoder (
	input  wire                          mipi_clk_2,
	input  wire                          reset,
	input  wire                          hs_active_i,
	input  wire csi_packet_pkg::word_t   word_i,
	input  wire                          word_stb_i,
	output logic                         hdr_stb_o,
	output csi_packet_pkg::data_type_e   dtype_o,
	output csi_packet_pkg::word_count_t  wcount_o,
	output csi_packet_pkg::word_t        pay_word_o,
	output logic                         pay_stb_o,
	output logic                         hdr_err_o
);
	import csi_packet_pkg::*;

	logic [7:0] syndrome;
	logic single;
	logic [4:0] flip_idx;
	logic [23:0] hdr_fixed;
	logic hdr_seen;
	logic pass_pay;

	//////////////////////////////
	// ecc check and single-bit fix
	always_comb begin
		syndrome = ecc_calc(word_i[23:0]) ^ word_i[31:24];
		single = ecc_syndrome_bit(syndrome, flip_idx);
		hdr_fixed = word_i[23:0];
		if (single) begin
			hdr_fixed[flip_idx] = ~hdr_fixed[flip_idx];
		end
	end

	always_ff @(posedge mipi_clk_2) begin
		if (word_stb_i) begin
			pay_word_o <= word_i;
		end
		if (word_stb_i && !hdr_seen) begin
			dtype_o <= data_type_e'(hdr_fixed[5:0]);
			wcount_o <= hdr_fixed[23:8];
		end
	end

	// first word of a burst is the header
	always_ff @(posedge mipi_clk_2) begin
		if (reset || !hs_active_i) begin
			hdr_seen <= 1'b0;
			pass_pay <= 1'b0;
			hdr_stb_o <= 1'b0;
			pay_stb_o <= 1'b0;
			hdr_err_o <= 1'b0;
		end else begin
			hdr_stb_o <= 1'b0;
			pay_stb_o <= 1'b0;
			hdr_err_o <= 1'b0;
			if (word_stb_i) begin
				if (!hdr_seen) begin
					hdr_seen <= 1'b1;
					if (syndrome == 8'h00 || single) begin
						hdr_stb_o <= 1'b1;
						pass_pay <= 1'b1;
					end else begin
						hdr_err_o <= 1'b1;
					end
				end else begin
					pay_stb_o <= pass_pay;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* line_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module line_writer (
	input  wire                          mipi_clk_2,
	input  wire                          reset,
	input  wire                          hdr_stb_i,
	input  wire csi_packet_pkg::data_type_e  dtype_i,
	input  wire csi_packet_pkg::word_count_t wcount_i,
	input  wire csi_packet_pkg::word_t   pay_word_i,
	input  wire                          pay_stb_i,
	output logic                         wr_en_o,
	output csi_packet_pkg::addr_t        wr_addr_o,
	output csi_packet_pkg::word_t        wr_data_o,
	output csi_packet_pkg::coord_t       pix_x_o,
	output csi_packet_pkg::coord_t       pix_y_o,
	output logic                         crc_ok_o,
	output logic                         crc_err_o
);
	import csi_packet_pkg::*;

	typedef enum logic [1:0] {
		idle,
		payload,
		checksum
	} line_state_e;

	line_state_e state;
	coord_t word_cnt;
	addr_t addr_cnt;
	crc_t crc;

	always_ff @(posedge mipi_clk_2) begin
		if (reset) begin
			state <= idle;
			word_cnt <= '0;
			addr_cnt <= '0;
			wr_en_o <= 1'b0;
			wr_addr_o <= '0;
			pix_x_o <= '0;
			pix_y_o <= '0;
			crc_ok_o <= 1'b0;
			crc_err_o <= 1'b0;
		end else begin
			wr_en_o <= 1'b0;
			crc_ok_o <= 1'b0;
			crc_err_o <= 1'b0;
			if (hdr_stb_i) begin
				// a new packet drops whatever line was open
				state <= idle;
				if (dtype_i == dt_frame_start) begin
					addr_cnt <= '0;
					pix_y_o <= '0;
				end else if (dtype_i == dt_raw8 && wcount_i == word_count_t'(line_bytes)) begin
					state <= payload;
					word_cnt <= '0;
					pix_x_o <= '0;
					crc <= crc_init;
				end
			end else if (pay_stb_i) begin
				case (state)
					payload: begin
						wr_en_o <= 1'b1;
						wr_data_o <= pay_word_i;
						wr_addr_o <= addr_cnt;
						pix_x_o <= word_cnt;
						addr_cnt <= addr_cnt + 1'b1;
						crc <= crc_next_word(crc, pay_word_i);
						if (word_cnt == coord_t'(line_words - 1)) begin
							state <= checksum;
						end else begin
							word_cnt <= word_cnt + 1'b1;
						end
					end
					checksum: begin
						// trailing word, low half carries the crc
						crc_ok_o <= (pay_word_i[15:0] == crc);
						crc_err_o <= (pay_word_i[15:0] != crc);
						pix_y_o <= pix_y_o + 1'b1;
						state <= idle;
					end
					default: begin
						state <= idle;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* sync_hunter.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_hunter (
	input  wire                     mipi_clk_2,
	input  wire                     reset,
	input  wire                     hs_active_i,
	input  wire csi_link_pkg::nibble_t nibble_i,
	output logic                    locked_o,
	output csi_link_pkg::phase_e    phase_o
);
	import csi_link_pkg::*;

	// newest nibble enters at the top
	byte_t window;

	always_ff @(posedge mipi_clk_2) begin
		if (reset || !hs_active_i) begin
			window <= '0;
			locked_o <= 1'b0;
			phase_o <= phase_even;
		end else begin
			window <= {nibble_i, window[7:4]};
			// lock and phase hold for the rest of the burst
			if (!locked_o) begin
				if (window == sync_even) begin
					locked_o <= 1'b1;
					phase_o <= phase_even;
				end else if (window[5:0] == sync_odd_low) begin
					locked_o <= 1'b1;
					phase_o <= phase_odd;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic mipi_clk_2,
	output logic reset
);

	// 100 ns period
	initial begin
		mipi_clk_2 = 1'b0;
		forever #50 mipi_clk_2 = ~mipi_clk_2;
	end

	initial begin
		reset = 1'b1;
		repeat (10) @(posedge mipi_clk_2);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

/* word_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module word_packer (
	input  wire                        mipi_clk_2,
	input  wire                        reset,
	input  wire                        hs_active_i,
	input  wire csi_link_pkg::byte_t   lane0_byte_i,
	input  wire csi_link_pkg::byte_t   lane1_byte_i,
	input  wire                        byte_stb_i,
	output csi_packet_pkg::word_t      word_o,
	output logic                       word_stb_o
);
	import csi_link_pkg::*;
	import csi_packet_pkg::*;

	// set once the low byte pair is held
	logic half;
	logic [15:0] low_half;

	always_ff @(posedge mipi_clk_2) begin
		if (byte_stb_i) begin
			if (!half) begin
				low_half <= {lane1_byte_i, lane0_byte_i};
			end else begin
				word_o <= {lane1_byte_i, lane0_byte_i, low_half};
			end
		end
	end

	always_ff @(posedge mipi_clk_2) begin
		if (reset || !hs_active_i) begin
			half <= 1'b0;
			word_stb_o <= 1'b0;
		end else begin
			word_stb_o <= byte_stb_i & half;
			if (byte_stb_i) begin
				half <= ~half;
			end
		end
	end

endmodule

`default_nettype wire
